//--- all.f
+incdir+verilog
verilog/chp_cfg_pkg.sv
verilog/chp_credit_pkg.sv
verilog/cq_scan_ctrl.sv
verilog/cq_vas_lookup.sv
verilog/vas_credit_store.sv
verilog/cq_onoff_eval.sv
verilog/chp_shared_pipe.sv
testbench/chp_pipe_checker.sv
testbench/tb_chp_shared_pipe.sv

//--- testbench/tb_chp_shared_pipe.sv
/* testbench top: clock, reset, threshold memory model, stimulus table
   with its loop, and the watchdog */
`timescale 1ns/1ns
`default_nettype none
`include "chp_defines.svh"

module tb_chp_shared_pipe;

  import chp_cfg_pkg::*;
  import chp_credit_pkg::*;

  localparam int NUM_ROWS = 25;
  localparam int FOCUS_CQ = 5;
  localparam int FOCUS_VAS = 3;

  typedef struct packed {
    logic [31:0]              palb;
    logic                     vas_bad;
    logic [`CHP_THRSH_W-1:0]  on_t;
    logic [`CHP_THRSH_W-1:0]  off_t;
    logic                     thr_bad;
    credit_wr_t               enq;
    credit_wr_t               sch;
    logic [3:0]               settle;
  } stim_row_t;

  logic                         hqm_gated_clk = 1'b0;
  logic                         hqm_gated_rst_b;
  logic                         reset_done;
  logic [31:0]                  palb_ctrl_reg;
  cq2vas_table_t                cq2vas_cfg;
  credit_wr_t                   enq_wr;
  credit_wr_t                   sch_wr;
  logic [`CHP_VASB2-1:0]        enq_raddr;
  logic [`CHP_VASB2-1:0]        sch_raddr;
  credit_count_t                enq_rdata;
  credit_count_t                sch_rdata;
  logic                         thrsh_re;
  logic [`CHP_NUM_LB_CQB2-1:0]  thrsh_addr;
  cq_thrsh_t                    thrsh_rdata;
  logic [`CHP_NUM_LB_CQ-1:0]    cq_off;
  logic                         sharepipe_error;
  logic                         open_req;
  logic                         check_req;
  logic [7:0]                   test_id;
  int                           err_count;
  int                           test_count;
  cq_thrsh_t                    thr_mem [`CHP_NUM_LB_CQ];
  stim_row_t                    rows [NUM_ROWS];
  int                           n_rows;
  int                           timeout_ns;
  logic                         table_ready = 1'b0;
  logic [31:0]                  lcg_state;

  chp_shared_pipe i_dut (.*);

  chp_pipe_checker i_chk (.*);

  always #5 hqm_gated_clk = ~hqm_gated_clk;

  // external threshold memory with one cycle of read latency
  always @(posedge hqm_gated_clk) begin
    if (thrsh_re) begin
      thrsh_rdata <= thr_mem[thrsh_addr];
    end
  end

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int period_cycles(logic [31:0] palb);
    if (palb[3:0] >= `CHP_PERIOD_MIN_SHIFT) begin
      return 1 << palb[3:0];
    end
    return `CHP_PERIOD_DEFAULT;
  endfunction

  function automatic cq2vas_entry_t build_entry(logic [`CHP_VASB2-1:0] v, logic bad);
    cq2vas_entry_t e;
    e.vas    = v;
    e.parity = ~(^v) ^ bad;
    return e;
  endfunction

  function automatic cq_thrsh_t build_thrsh(logic [14:0] on_t, logic [14:0] off_t, logic bad);
    cq_thrsh_t t;
    t.on_thrsh  = on_t;
    t.off_thrsh = off_t;
    t.parity[0] = ~(^on_t) ^ bad;
    t.parity[1] = ~(^off_t);
    return t;
  endfunction

  task automatic add_row(logic [31:0] palb, int on_t, int off_t, logic thr_bad, logic vas_bad,
                         logic ew, int ea, int ed, logic sw, int sa, int sd, int settle);
    rows[n_rows] = '{palb, vas_bad, on_t[14:0], off_t[14:0], thr_bad,
                     '{ew, ea[4:0], '{ed[14:0]}}, '{sw, sa[4:0], '{sd[14:0]}}, settle[3:0]};
    n_rows++;
  endtask

  // ------------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------------
  task automatic build_table();
    n_rows = 0;
    add_row(32'h0000_0000, 100, 200, 0, 0, 1, 3, 500, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 0, 0, 0, 1, 3, 50, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 1, 3, 500, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 0, 0, 0, 1, 3, 150, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 1, 3, 100, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 0, 0, 0, 1, 3, 150, 2);
    add_row(32'h8000_0008, 100, 200, 0, 0, 1, 3, 500, 0, 0, 0, 1);
    add_row(32'h8000_0008, 100, 200, 0, 0, 0, 0, 0, 1, 3, 150, 1);
    add_row(32'h8000_0008, 100, 200, 0, 0, 1, 3, 90, 0, 0, 0, 1);
    add_row(32'h8000_0008, 100, 200, 0, 0, 0, 0, 0, 1, 3, 180, 1);
    add_row(32'h8000_0000, 100, 200, 0, 0, 1, 3, 500, 0, 0, 0, 2);
    add_row(32'h8000_0000, 200, 200, 0, 0, 0, 0, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 0, 0, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 0, 200, 0, 0, 0, 0, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 0, 0, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 0, 0, 0, 0, 0, 0, 2);
    // the focus cq is off here, so dropping the enable must clear it
    add_row(32'h0000_0000, 100, 200, 0, 0, 1, 3, 600, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 1, 3, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 1, 7, 1234, 1, 9, 4321, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 1, 7, 11, 1, 7, 22, 2);
    add_row(32'h8000_0000, 100, 200, 0, 1, 0, 0, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 0, 0, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 1, 0, 0, 0, 0, 0, 0, 0, 2);
    add_row(32'h8000_0000, 100, 200, 0, 0, 0, 0, 0, 0, 0, 0, 2);
  endtask

  initial begin
    int per;
    int total;
    int on_r;
    hqm_gated_rst_b = 1'b0;
    reset_done      = 1'b0;
    palb_ctrl_reg   = '0;
    enq_wr          = '0;
    sch_wr          = '0;
    enq_raddr       = '0;
    sch_raddr       = '0;
    thrsh_rdata     = '0;
    open_req        = 1'b0;
    check_req       = 1'b0;
    test_id         = '0;
    lcg_state       = 32'h296a_0d90;
    // background cqs get a random vas and thresholds with on below off
    for (int c = 0; c < `CHP_NUM_LB_CQ; c++) begin
      lcg_state     = lcg_next(lcg_state);
      on_r          = (lcg_state[23:8] % 1000) + 1;
      cq2vas_cfg[c] = build_entry(lcg_state[4:0], 1'b0);
      lcg_state     = lcg_next(lcg_state);
      thr_mem[c]    = build_thrsh(on_r, on_r + (lcg_state[23:8] % 1000) + 1, 1'b0);
    end
    build_table();
    total = 0;
    for (int i = 0; i < n_rows; i++) begin
      total += period_cycles(rows[i].palb) * (rows[i].settle + 1) + 20;
    end
    timeout_ns  = 2 * total * 10 + 200;
    table_ready = 1'b1;

    repeat (8) @(posedge hqm_gated_clk);
    hqm_gated_rst_b <= 1'b1;
    @(posedge hqm_gated_clk);
    reset_done <= 1'b1;

    for (int i = 0; i < n_rows; i++) begin
      per = period_cycles(rows[i].palb);
      @(posedge hqm_gated_clk);
      palb_ctrl_reg        <= rows[i].palb;
      cq2vas_cfg[FOCUS_CQ] <= build_entry(FOCUS_VAS, rows[i].vas_bad);
      thr_mem[FOCUS_CQ]    <= build_thrsh(rows[i].on_t, rows[i].off_t, rows[i].thr_bad);
      // one full period lets every cq see the new configuration
      repeat (per + 8) @(posedge hqm_gated_clk);
      open_req  <= 1'b1;
      test_id   <= i;
      enq_wr    <= rows[i].enq;
      sch_wr    <= rows[i].sch;
      enq_raddr <= rows[i].enq.addr;
      sch_raddr <= rows[i].sch.addr;
      @(posedge hqm_gated_clk);
      open_req <= 1'b0;
      enq_wr   <= '0;
      sch_wr   <= '0;
      repeat (rows[i].settle * per + 8) @(posedge hqm_gated_clk);
      check_req <= 1'b1;
      @(posedge hqm_gated_clk);
      check_req <= 1'b0;
    end
    repeat (2) @(posedge hqm_gated_clk);

    $display("tests run %0d of %0d, mismatches %0d", test_count, n_rows, err_count);
    if (err_count == 0 && test_count == n_rows) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #(timeout_ns);
    $display("watchdog expired after %0d ns before the tests finished", timeout_ns);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/chp_pipe_checker.sv
/* reference model and compare for the shared pipe: credit copy, threshold
   copy, expected off bits and error window, with the per-test report */
`timescale 1ns/1ns
`default_nettype none
`include "chp_defines.svh"

module chp_pipe_checker (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_b,
  input  logic                          reset_done,
  input  logic [31:0]                   palb_ctrl_reg,
  input  chp_cfg_pkg::cq2vas_table_t    cq2vas_cfg,
  input  chp_credit_pkg::credit_wr_t    enq_wr,
  input  chp_credit_pkg::credit_wr_t    sch_wr,
  input  logic [`CHP_VASB2-1:0]         enq_raddr,
  input  logic [`CHP_VASB2-1:0]         sch_raddr,
  input  chp_credit_pkg::credit_count_t enq_rdata,
  input  chp_credit_pkg::credit_count_t sch_rdata,
  input  logic                          thrsh_re,
  input  logic [`CHP_NUM_LB_CQB2-1:0]   thrsh_addr,
  input  chp_credit_pkg::cq_thrsh_t     thrsh_rdata,
  input  logic [`CHP_NUM_LB_CQ-1:0]     cq_off,
  input  logic                          sharepipe_error,
  input  logic                          open_req,
  input  logic                          check_req,
  input  logic [7:0]                    test_id,
  output int                            err_count,
  output int                            test_count
);

  import chp_cfg_pkg::*;
  import chp_credit_pkg::*;

  logic [`CHP_COUNT_W-1:0]      cred [`CHP_NUM_VAS];
  cq_thrsh_t                    thr [`CHP_NUM_LB_CQ];
  logic [`CHP_NUM_LB_CQ-1:0]    off_exp;
  logic                         re_d;
  logic [`CHP_NUM_LB_CQB2-1:0]  addr_d;
  logic                         en_m;
  logic [`CHP_PERIOD_W-1:0]     per_m;
  logic [`CHP_PERIOD_W-1:0]     ctr_m;
  logic                         coll_seen;
  logic                         err_seen;
  int                           errs_at_open;

  initial begin
    err_count  = 0;
    test_count = 0;
  end

  // hysteresis rule for one cq given its current state
  function automatic logic next_off(logic cur, logic [`CHP_COUNT_W-1:0] cnt, cq_thrsh_t t);
    if (t.on_thrsh == t.off_thrsh || t.on_thrsh == 0 || t.off_thrsh == 0 || cnt == 0) begin
      return 1'b0;
    end
    if (cur) begin
      return !(cnt <= t.on_thrsh);
    end
    return cnt > t.off_thrsh;
  endfunction

  // period from the palb shift field, small fields fall back to the default
  function automatic logic [`CHP_PERIOD_W-1:0] decode_period(logic [3:0] fld);
    if (fld >= `CHP_PERIOD_MIN_SHIFT) begin
      return 1 << fld;
    end
    return `CHP_PERIOD_DEFAULT;
  endfunction

  // compare the read strobe with the model, then advance the scan counter model
  task automatic check_scan_read();
    logic [`CHP_PERIOD_W-1:0] per_nxt;
    if (thrsh_re !== re_d || (re_d && thrsh_addr !== addr_d)) begin
      $display("FAILED at %0t: threshold read %0b at %0d, expected %0b at %0d",
               $time, thrsh_re, thrsh_addr, re_d, addr_d);
      err_count++;
    end
    per_nxt = decode_period(palb_ctrl_reg[3:0]);
    if (reset_done && en_m) begin
      if (per_nxt != per_m || ctr_m >= per_m) begin
        ctr_m = '0;
      end else begin
        ctr_m = ctr_m + 1'b1;
      end
    end
    en_m  = palb_ctrl_reg[31];
    per_m = per_nxt;
  endtask

  task automatic update_off_model();
    for (int c = 0; c < `CHP_NUM_LB_CQ; c++) begin
      if (!palb_ctrl_reg[31]) begin
        off_exp[c] = 1'b0;
      end else begin
        off_exp[c] = next_off(off_exp[c], cred[cq2vas_cfg[c].vas], thr[c]);
      end
    end
  endtask

  function automatic logic parity_fault();
    logic bad;
    bad = 1'b0;
    for (int c = 0; c < `CHP_NUM_LB_CQ; c++) begin
      bad |= ~(^{cq2vas_cfg[c].parity, cq2vas_cfg[c].vas});
      bad |= ~(^{thr[c].parity[0], thr[c].on_thrsh});
      bad |= ~(^{thr[c].parity[1], thr[c].off_thrsh});
    end
    return bad;
  endfunction

  task automatic compare_test();
    logic exp_err;
    update_off_model();
    exp_err = coll_seen | (palb_ctrl_reg[31] & parity_fault());
    if (cq_off !== off_exp) begin
      $display("FAILED at %0t: test %0d cq_off %h, expected %h", $time, test_id, cq_off, off_exp);
      err_count++;
    end
    if (enq_rdata.count !== cred[enq_raddr] || sch_rdata.count !== cred[sch_raddr]) begin
      $display("FAILED at %0t: test %0d read data enq %0d sch %0d, expected %0d and %0d",
               $time, test_id, enq_rdata.count, sch_rdata.count,
               cred[enq_raddr], cred[sch_raddr]);
      err_count++;
    end
    if (err_seen !== exp_err) begin
      $display("FAILED at %0t: test %0d sharepipe_error seen %0b, expected %0b",
               $time, test_id, err_seen, exp_err);
      err_count++;
    end
    if (err_count == errs_at_open) begin
      $display("test %0d ok", test_id);
    end else begin
      $display("test %0d had mismatches", test_id);
    end
    test_count++;
  endtask

  // ------------------------------------------------------------------------
  // sampled on the rising edge, before any update of that edge lands
  // ------------------------------------------------------------------------
  always @(posedge hqm_gated_clk) begin
    if (!hqm_gated_rst_b) begin
      for (int v = 0; v < `CHP_NUM_VAS; v++) begin
        cred[v] = '0;
      end
      off_exp   = '0;
      re_d      = 1'b0;
      en_m      = 1'b0;
      per_m     = '0;
      ctr_m     = '0;
      coll_seen = 1'b0;
      err_seen  = 1'b0;
    end else begin
      if (re_d) begin
        thr[addr_d] = thrsh_rdata;
      end
      re_d   = reset_done & en_m & (ctr_m < `CHP_NUM_LB_CQ);
      addr_d = ctr_m[`CHP_NUM_LB_CQB2-1:0];
      check_scan_read();
      if (sharepipe_error) begin
        err_seen = 1'b1;
      end
      // the new configuration was scanned with the counts from before this row's writes
      if (open_req) begin
        update_off_model();
        err_seen     = 1'b0;
        coll_seen    = 1'b0;
        errs_at_open = err_count;
      end
      if (enq_wr.we && sch_wr.we && enq_wr.addr == sch_wr.addr) begin
        coll_seen = 1'b1;
      end else begin
        if (enq_wr.we) begin
          cred[enq_wr.addr] = enq_wr.data.count;
        end
        if (sch_wr.we) begin
          cred[sch_wr.addr] = sch_wr.data.count;
        end
      end
      if (check_req) begin
        compare_test();
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/chp_shared_pipe.sv
/* shared pipe top: scan controller, cq2vas lookup, credit store and
   on/off evaluation wired together */
`timescale 1ns/1ns
`default_nettype none
`include "chp_defines.svh"

module chp_shared_pipe (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_b,
  input  logic                          reset_done,
  input  logic [31:0]                   palb_ctrl_reg,
  input  chp_cfg_pkg::cq2vas_table_t    cq2vas_cfg,
  input  chp_credit_pkg::credit_wr_t    enq_wr,
  input  chp_credit_pkg::credit_wr_t    sch_wr,
  input  logic [`CHP_VASB2-1:0]         enq_raddr,
  input  logic [`CHP_VASB2-1:0]         sch_raddr,
  output chp_credit_pkg::credit_count_t enq_rdata,
  output chp_credit_pkg::credit_count_t sch_rdata,
  output logic                          thrsh_re,
  output logic [`CHP_NUM_LB_CQB2-1:0]   thrsh_addr,
  input  chp_credit_pkg::cq_thrsh_t     thrsh_rdata,
  output logic [`CHP_NUM_LB_CQ-1:0]     cq_off,
  output logic                          sharepipe_error
);

  import chp_credit_pkg::*;

  logic                         palb_en;
  logic                         scan_v;
  logic [`CHP_NUM_LB_CQB2-1:0]  scan_cq;
  logic                         coll_err;
  logic                         vas_par_err;
  logic                         thrsh_par_err;
  scan_p1_t                     scan_p1;
  credit_count_t                scan_credit;

  cq_scan_ctrl i_cq_scan_ctrl (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_b (hqm_gated_rst_b),
    .reset_done      (reset_done),
    .palb_ctrl_reg   (palb_ctrl_reg),
    .coll_err        (coll_err),
    .vas_par_err     (vas_par_err),
    .thrsh_par_err   (thrsh_par_err),
    .palb_en         (palb_en),
    .scan_v          (scan_v),
    .scan_cq         (scan_cq),
    .thrsh_re        (thrsh_re),
    .thrsh_addr      (thrsh_addr),
    .sharepipe_error (sharepipe_error)
  );

  cq_vas_lookup i_cq_vas_lookup (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_b (hqm_gated_rst_b),
    .scan_v          (scan_v),
    .scan_cq         (scan_cq),
    .cq2vas_cfg      (cq2vas_cfg),
    .scan_p1         (scan_p1),
    .vas_par_err     (vas_par_err)
  );

  vas_credit_store i_vas_credit_store (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_b (hqm_gated_rst_b),
    .enq_wr          (enq_wr),
    .sch_wr          (sch_wr),
    .enq_raddr       (enq_raddr),
    .sch_raddr       (sch_raddr),
    .scan_p1         (scan_p1),
    .enq_rdata       (enq_rdata),
    .sch_rdata       (sch_rdata),
    .scan_credit     (scan_credit),
    .coll_err        (coll_err)
  );

  cq_onoff_eval i_cq_onoff_eval (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_b (hqm_gated_rst_b),
    .palb_en         (palb_en),
    .scan_p1         (scan_p1),
    .thrsh_rdata     (thrsh_rdata),
    .scan_credit     (scan_credit),
    .cq_off          (cq_off),
    .thrsh_par_err   (thrsh_par_err)
  );

endmodule

`default_nettype wire

//--- verilog/cq_onoff_eval.sv
/* stage-2 threshold capture, threshold parity and the cq off-bit
   hysteresis update */
`timescale 1ns/1ns
`default_nettype none
`include "chp_defines.svh"

module cq_onoff_eval (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_b,
  input  logic                          palb_en,
  input  chp_credit_pkg::scan_p1_t      scan_p1,
  input  chp_credit_pkg::cq_thrsh_t     thrsh_rdata,
  input  chp_credit_pkg::credit_count_t scan_credit,
  output logic [`CHP_NUM_LB_CQ-1:0]     cq_off,
  output logic                          thrsh_par_err
);

  import chp_credit_pkg::*;

  logic                         p2_v_f;
  logic [`CHP_NUM_LB_CQB2-1:0]  p2_cq_f;
  cq_thrsh_t                    p2_thrsh_f;
  logic [1:0]                   par_bad;
  logic                         force_on;
  logic                         go_off;
  logic                         go_on;
  logic [`CHP_NUM_LB_CQ-1:0]    cq_off_nxt;
  logic [`CHP_NUM_LB_CQ-1:0]    cq_off_f;

  // ------------------------------------------------------------------------
  // stage 2 capture
  // ------------------------------------------------------------------------
  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      p2_v_f <= 1'b0;
    end else begin
      p2_v_f <= scan_p1.valid;
    end
  end

  // memory data arrives the cycle after the read, together with stage 1
  always_ff @(posedge hqm_gated_clk) begin
    if (scan_p1.valid) begin
      p2_cq_f    <= scan_p1.cq;
      p2_thrsh_f <= thrsh_rdata;
    end
  end

  assign par_bad[0]    = ~(^{p2_thrsh_f.parity[0], p2_thrsh_f.on_thrsh});
  assign par_bad[1]    = ~(^{p2_thrsh_f.parity[1], p2_thrsh_f.off_thrsh});
  assign thrsh_par_err = p2_v_f & (|par_bad);

  // ------------------------------------------------------------------------
  // hysteresis compare
  // ------------------------------------------------------------------------

  // degenerate thresholds or an empty pool keep the cq on
  assign force_on = (p2_thrsh_f.on_thrsh == p2_thrsh_f.off_thrsh) |
                    (p2_thrsh_f.on_thrsh == '0) |
                    (p2_thrsh_f.off_thrsh == '0) |
                    (scan_credit.count == '0);
  assign go_off   = (scan_credit.count > p2_thrsh_f.off_thrsh);
  assign go_on    = (scan_credit.count <= p2_thrsh_f.on_thrsh);

  always_comb begin
    cq_off_nxt = cq_off_f;
    if (!palb_en) begin
      cq_off_nxt = '0;
    end else if (p2_v_f) begin
      if (force_on) begin
        cq_off_nxt[p2_cq_f] = 1'b0;
      end else if (cq_off_f[p2_cq_f]) begin
        cq_off_nxt[p2_cq_f] = ~go_on;
      end else begin
        cq_off_nxt[p2_cq_f] = go_off;
      end
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      cq_off_f <= '0;
    end else begin
      cq_off_f <= cq_off_nxt;
    end
  end

  assign cq_off = cq_off_f;

  // stage 2 is only ever fed by a valid lookup one cycle earlier
  a_p2_follows_p1 : assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_b)
    p2_v_f |-> $past(scan_p1.valid)
  );

endmodule

`default_nettype wire

//--- verilog/vas_credit_store.sv
/* vas credit count store: two write ports with collision drop,
   two combinational read ports and the stage-2 scan read */
`timescale 1ns/1ns
`default_nettype none
`include "chp_defines.svh"

module vas_credit_store (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_b,
  input  chp_credit_pkg::credit_wr_t    enq_wr,
  input  chp_credit_pkg::credit_wr_t    sch_wr,
  input  logic [`CHP_VASB2-1:0]         enq_raddr,
  input  logic [`CHP_VASB2-1:0]         sch_raddr,
  input  chp_credit_pkg::scan_p1_t      scan_p1,
  output chp_credit_pkg::credit_count_t enq_rdata,
  output chp_credit_pkg::credit_count_t sch_rdata,
  output chp_credit_pkg::credit_count_t scan_credit,
  output logic                          coll_err
);

  import chp_credit_pkg::*;

  credit_count_t  cnt_f [`CHP_NUM_VAS];
  logic           same_addr;
  logic           enq_wr_en;
  logic           sch_wr_en;

  // ------------------------------------------------------------------------
  // write ports
  // ------------------------------------------------------------------------

  // same-address writes in one cycle are both lost and flagged
  assign same_addr = (enq_wr.addr == sch_wr.addr);
  assign coll_err  = enq_wr.we & sch_wr.we & same_addr;
  assign enq_wr_en = enq_wr.we & ~coll_err;
  assign sch_wr_en = sch_wr.we & ~coll_err;

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      for (int i = 0; i < `CHP_NUM_VAS; i++) begin
        cnt_f[i] <= '0;
      end
    end else begin
      if (enq_wr_en) begin
        cnt_f[enq_wr.addr] <= enq_wr.data;
      end
      if (sch_wr_en) begin
        cnt_f[sch_wr.addr] <= sch_wr.data;
      end
    end
  end

  // ------------------------------------------------------------------------
  // read ports
  // ------------------------------------------------------------------------
  assign enq_rdata = cnt_f[enq_raddr];
  assign sch_rdata = cnt_f[sch_raddr];

  // count sampled for the scanned cq, lines up with the threshold word
  always_ff @(posedge hqm_gated_clk) begin
    if (scan_p1.valid) begin
      scan_credit <= cnt_f[scan_p1.vas];
    end
  end

endmodule

`default_nettype wire

//--- verilog/cq_vas_lookup.sv
/* stage-1 cq2vas lookup with its odd parity check */
`timescale 1ns/1ns
`default_nettype none
`include "chp_defines.svh"

module cq_vas_lookup (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_b,
  input  logic                          scan_v,
  input  logic [`CHP_NUM_LB_CQB2-1:0]   scan_cq,
  input  chp_cfg_pkg::cq2vas_table_t    cq2vas_cfg,
  output chp_credit_pkg::scan_p1_t      scan_p1,
  output logic                          vas_par_err
);

  import chp_cfg_pkg::*;

  cq2vas_entry_t                entry_sel;
  cq2vas_entry_t                p1_entry_f;
  logic                         p1_v_f;
  logic [`CHP_NUM_LB_CQB2-1:0]  p1_cq_f;

  assign entry_sel = cq2vas_cfg[scan_cq];

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      p1_v_f <= 1'b0;
    end else begin
      p1_v_f <= scan_v;
    end
  end

  always_ff @(posedge hqm_gated_clk) begin
    if (scan_v) begin
      p1_cq_f    <= scan_cq;
      p1_entry_f <= entry_sel;
    end
  end

  assign scan_p1.valid  = p1_v_f;
  assign scan_p1.cq     = p1_cq_f;
  assign scan_p1.vas    = p1_entry_f.vas;
  assign scan_p1.parity = p1_entry_f.parity;

  // good entries xor to one over the vas number and the parity bit
  assign vas_par_err = p1_v_f & ~(^{p1_entry_f.parity, p1_entry_f.vas});

endmodule

`default_nettype wire

//--- verilog/cq_scan_ctrl.sv
/* scan controller: palb decode, scan counter, threshold read issue
   and the registered error summary */
`timescale 1ns/1ns
`default_nettype none
`include "chp_defines.svh"

module cq_scan_ctrl (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_b,
  input  logic                          reset_done,
  input  logic [31:0]                   palb_ctrl_reg,
  input  logic                          coll_err,
  input  logic                          vas_par_err,
  input  logic                          thrsh_par_err,
  output logic                          palb_en,
  output logic                          scan_v,
  output logic [`CHP_NUM_LB_CQB2-1:0]   scan_cq,
  output logic                          thrsh_re,
  output logic [`CHP_NUM_LB_CQB2-1:0]   thrsh_addr,
  output logic                          sharepipe_error
);

  import chp_cfg_pkg::*;

  localparam logic [`CHP_PERIOD_W-1:0] PERIOD_DFLT = `CHP_PERIOD_DEFAULT;
  localparam logic [`CHP_PERIOD_W-1:0] NUM_CQ      = `CHP_NUM_LB_CQ;

  palb_ctrl_t                 palb_nxt;
  palb_ctrl_t                 palb_f;
  logic [3:0]                 period_fld;
  logic                       period_chg;
  logic                       scan_run;
  logic                       scan_hit;
  logic [`CHP_PERIOD_W-1:0]   scan_ctr_nxt;
  logic [`CHP_PERIOD_W-1:0]   scan_ctr_f;
  logic                       err_nxt;
  logic                       err_f;

  // ------------------------------------------------------------------------
  // palb control decode
  // ------------------------------------------------------------------------
  always_comb begin
    period_fld      = palb_ctrl_reg[3:0];
    palb_nxt.enable = palb_ctrl_reg[31];
    palb_nxt.period = PERIOD_DFLT;
    if (period_fld >= `CHP_PERIOD_MIN_SHIFT) begin
      palb_nxt.period             = '0;
      palb_nxt.period[period_fld] = 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // scan counter
  // ------------------------------------------------------------------------
  assign period_chg = (palb_nxt.period != palb_f.period);
  assign scan_run   = reset_done & palb_f.enable;

  // restart the walk on a new period so the first 64 counts always scan
  always_comb begin
    scan_ctr_nxt = scan_ctr_f;
    if (scan_run) begin
      if (period_chg || (scan_ctr_f >= palb_f.period)) begin
        scan_ctr_nxt = '0;
      end else begin
        scan_ctr_nxt = scan_ctr_f + 1'b1;
      end
    end
  end

  // one scan and one threshold read per cq at the head of each period
  assign scan_hit   = scan_run & (scan_ctr_f < NUM_CQ);
  assign scan_v     = scan_hit;
  assign scan_cq    = scan_ctr_f[`CHP_NUM_LB_CQB2-1:0];
  assign thrsh_re   = scan_hit;
  assign thrsh_addr = scan_ctr_f[`CHP_NUM_LB_CQB2-1:0];

  assign palb_en = palb_f.enable;

  assign err_nxt         = coll_err | vas_par_err | thrsh_par_err;
  assign sharepipe_error = err_f;

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      palb_f     <= '0;
      scan_ctr_f <= '0;
      err_f      <= 1'b0;
    end else begin
      palb_f     <= palb_nxt;
      scan_ctr_f <= scan_ctr_nxt;
      err_f      <= err_nxt;
    end
  end

  // a read may only start after the raw enable bit was loaded on the prior edge
  a_thrsh_re_needs_en : assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_b)
    $rose(thrsh_re) |-> $past(palb_ctrl_reg[31])
  );

endmodule

`default_nettype wire

//--- verilog/chp_credit_pkg.sv
/* credit and threshold types: count word, threshold word, write port
   and the stage-1 scan struct */
`default_nettype none
`include "chp_defines.svh"

package chp_credit_pkg;

  typedef struct packed {
    logic [`CHP_COUNT_W-1:0]    count;
  } credit_count_t;

  // parity[0] covers on_thrsh, parity[1] covers off_thrsh, both odd
  typedef struct packed {
    logic [1:0]                 parity;
    logic [`CHP_THRSH_W-1:0]    off_thrsh;
    logic [`CHP_THRSH_W-1:0]    on_thrsh;
  } cq_thrsh_t;

  typedef struct packed {
    logic                       we;
    logic [`CHP_VASB2-1:0]      addr;
    credit_count_t              data;
  } credit_wr_t;

  // ------------------------------------------------------------------------
  // scan pipeline
  // ------------------------------------------------------------------------

  typedef struct packed {
    logic                       valid;
    logic [`CHP_NUM_LB_CQB2-1:0] cq;
    logic [`CHP_VASB2-1:0]      vas;
    logic                       parity;
  } scan_p1_t;

endpackage

`default_nettype wire

//--- verilog/chp_cfg_pkg.sv
/* configuration types: decoded load-balance control and the cq2vas table */
`default_nettype none
`include "chp_defines.svh"

package chp_cfg_pkg;

  // ------------------------------------------------------------------------
  // load-balance control
  // ------------------------------------------------------------------------

  // period holds the expanded value, not the raw shift field
  typedef struct packed {
    logic                       enable;
    logic [`CHP_PERIOD_W-1:0]   period;
  } palb_ctrl_t;

  // ------------------------------------------------------------------------
  // cq to vas mapping
  // ------------------------------------------------------------------------

  // parity is odd over the vas number and itself
  typedef struct packed {
    logic                       parity;
    logic [`CHP_VASB2-1:0]      vas;
  } cq2vas_entry_t;

  // entry n sits at bits n*6 +: 6
  typedef cq2vas_entry_t [`CHP_NUM_LB_CQ-1:0] cq2vas_table_t;

endpackage

`default_nettype wire

//--- verilog/chp_defines.svh
/* sizing macros for the credit history shared pipe: cq and vas counts,
   field widths and the scan period defaults */
`ifndef CHP_DEFINES_SVH
`define CHP_DEFINES_SVH

// load-balanced cq population and index width
`define CHP_NUM_LB_CQ         64
`define CHP_NUM_LB_CQB2       6

// vas credit pool
`define CHP_NUM_VAS           32
`define CHP_VASB2             5

// credit count and threshold field widths
`define CHP_COUNT_W           15
`define CHP_THRSH_W           15

// scan counter width and period decode
`define CHP_PERIOD_W          16
`define CHP_PERIOD_DEFAULT    64

// period fields below this value fall back to the default period
`define CHP_PERIOD_MIN_SHIFT  7

`endif
